/* src/pong_geometry_pkg.sv */
package pong_geometry_pkg;

    typedef logic [9:0] coord_t;    // Screen coordinate in pixels
    typedef logic [7:0] score_t;    // Player score, wraps at 255
    typedef logic [9:0] sensor_t;   // Raw distance sensor reading

    // Playing field
    localparam coord_t FIELD_HEIGHT = 10'd120;  // Visible rows
    localparam coord_t FIELD_BOTTOM = 10'd118;  // Ball turns up when y + BALL_SIZE hits this

    // Object sizes
    localparam coord_t BALL_SIZE    = 10'd2;    // Ball is a 2x2 square
    localparam coord_t PADDLE_LEN   = 10'd16;
    localparam coord_t PADDLE_MAX_Y = FIELD_HEIGHT - PADDLE_LEN;   // 104, paddle stays on screen

    // Paddle columns
    localparam coord_t P1_X = 10'd15;
    localparam coord_t P2_X = 10'd144;

    // Serve point, also the position after a restart
    localparam coord_t BALL_START_X = 10'd80;
    localparam coord_t BALL_START_Y = 10'd60;

    // Sensor window and scaling
    localparam sensor_t SENSOR_MIN   = 10'd2;   // Readings below this are the blind spot
    localparam sensor_t SENSOR_LIMIT = 10'd20;  // Readings at or above this are out of range
    localparam coord_t  SENSOR_SCALE = 10'd7;   // Pixels per sensor unit

    // Paddle step table, larger gap gives a larger step
    localparam coord_t GAP_FAR   = 10'd80;
    localparam coord_t GAP_MID   = 10'd50;
    localparam coord_t GAP_NEAR  = 10'd20;
    localparam coord_t STEP_FAR  = 10'd40;
    localparam coord_t STEP_MID  = 10'd20;
    localparam coord_t STEP_NEAR = 10'd4;
    localparam coord_t STEP_FINE = 10'd1;   // Final approach, one pixel per frame

endpackage

/* src/pong_frame_pkg.sv */
package pong_frame_pkg;

    import pong_geometry_pkg::*;

    // Frame request as it arrives from the game loop
    typedef struct packed {
        logic    restart;   // Back to the serve state, no scoring
        sensor_t sensor_1;  // Player 1 hand distance
        sensor_t sensor_2;  // Player 2 hand distance
    } frame_req_t;

    // One paddle's decoded sensor
    typedef struct packed {
        logic   track;      // Reading inside the valid window
        coord_t target;     // Wanted paddle y, only meaningful with track
    } paddle_target_t;

    // Decoded request handed to the physics stage
    typedef struct packed {
        logic           restart;
        paddle_target_t paddle_1;
        paddle_target_t paddle_2;
    } frame_cmd_t;

    // Game state reported after each frame
    typedef struct packed {
        coord_t ball_x;
        coord_t ball_y;
        coord_t paddle_1_y;
        coord_t paddle_2_y;
        score_t score_1;
        score_t score_2;
    } frame_result_t;

    // Serve state loaded by reset and by restart
    localparam frame_result_t START_FRAME = '{
        ball_x:     BALL_START_X,
        ball_y:     BALL_START_Y,
        paddle_1_y: 10'd0,
        paddle_2_y: 10'd0,
        score_1:    8'd0,
        score_2:    8'd0
    };

endpackage

/* src/paddle_target_decode.sv */
`timescale 1ns/1ps

module paddle_target_decode import pong_geometry_pkg::*, pong_frame_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,

    // Request side
    input  logic       in_valid,
    output logic       in_ready,
    input  frame_req_t in_req,

    // Command side towards physics
    output logic       out_valid,
    input  logic       out_ready,
    output frame_cmd_t out_cmd
);

    frame_cmd_t cmd_next;   // Decoded form of the incoming request
    logic       take;       // Request transfer this cycle

    // Sensor reading to paddle target
    // Blind spot and out of range readings give no tracking
    function automatic paddle_target_t decode_sensor(input sensor_t reading);
        paddle_target_t result;
        result.track = (reading >= SENSOR_MIN) && (reading < SENSOR_LIMIT);
        if (result.track)
        begin
            // Nearest valid reading maps to the top row
            result.target = coord_t'((reading - SENSOR_MIN) * SENSOR_SCALE);
        end
        else
        begin
            result.target = '0;
        end
        return result;
    endfunction

    always_comb
    begin
        cmd_next.restart  = in_req.restart;                 // Passes straight through
        cmd_next.paddle_1 = decode_sensor(in_req.sensor_1);
        cmd_next.paddle_2 = decode_sensor(in_req.sensor_2);
    end

    // One entry stage, refills in the cycle it drains
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
        end
        else if (take)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;  // Drained, nothing new behind it
        end
    end

    // Payload register, only written on a transfer
    always_ff @(posedge clock)
    begin
        if (take)
        begin
            out_cmd <= cmd_next;
        end
    end

endmodule

/* src/pong_physics_execute.sv */
`timescale 1ns/1ps

module pong_physics_execute import pong_geometry_pkg::*, pong_frame_pkg::*;
(
    input  logic          clock,
    input  logic          resetn,

    // Command side from decode
    input  logic          in_valid,
    output logic          in_ready,
    input  frame_cmd_t    in_cmd,

    // Step side towards the result buffer
    output logic          out_valid,
    input  logic          out_ready,
    output frame_result_t out_step
);

    frame_result_t state_q;     // Ball, paddles and scores
    frame_result_t state_next;
    logic          dir_x_q;     // 1 moves right
    logic          dir_y_q;     // 1 moves down
    logic          dir_x_next;
    logic          dir_y_next;
    logic          hit_1;       // Ball returned by paddle 1
    logic          hit_2;       // Ball returned by paddle 2
    logic          miss_1;      // Player 1 missed, player 2 scores
    logic          miss_2;      // Player 2 missed, player 1 scores
    logic          take;

    // Vertical overlap between ball and a paddle
    function automatic logic overlaps(input coord_t ball_y, input coord_t paddle_y);
        return (ball_y + BALL_SIZE >= paddle_y) &&
               (ball_y <= paddle_y + PADDLE_LEN - 10'd1);
    endfunction

    // Move a paddle towards its target using the step table
    function automatic coord_t move_paddle(input coord_t pos, input paddle_target_t tgt);
        coord_t gap;
        coord_t step;
        coord_t moved;
        gap = (tgt.target > pos) ? tgt.target - pos : pos - tgt.target;
        if (gap > GAP_FAR)
            step = STEP_FAR;
        else if (gap > GAP_MID)
            step = STEP_MID;
        else if (gap > GAP_NEAR)
            step = STEP_NEAR;
        else
            step = STEP_FINE;   // Never larger than a nonzero gap
        if (!tgt.track)
            moved = pos;        // Hand not seen, paddle holds
        else if (tgt.target > pos)
            moved = pos + step;
        else if (tgt.target < pos)
            moved = pos - step;
        else
            moved = pos;        // Already on target
        // Targets up to 119 exist, keep the paddle fully on screen
        if (moved > PADDLE_MAX_Y)
            moved = PADDLE_MAX_Y;
        return moved;
    endfunction

    // Decisions all look at the state from before this frame
    assign hit_1  = !dir_x_q && (state_q.ball_x == P1_X + 10'd1) &&
                    overlaps(state_q.ball_y, state_q.paddle_1_y);
    assign hit_2  = dir_x_q && (state_q.ball_x + BALL_SIZE == P2_X) &&
                    overlaps(state_q.ball_y, state_q.paddle_2_y);
    assign miss_1 = (state_q.ball_x == P1_X - 10'd1);               // Past paddle 1
    assign miss_2 = (state_q.ball_x + BALL_SIZE == P2_X + 10'd1);   // Past paddle 2

    always_comb
    begin
        state_next = state_q;
        dir_x_next = dir_x_q;
        dir_y_next = dir_y_q;

        if (in_cmd.restart)
        begin
            state_next = START_FRAME;
            dir_x_next = 1'b1;  // Serve right and down
            dir_y_next = 1'b1;
        end
        else
        begin
            // Paddle bounces
            if (hit_1)
                dir_x_next = 1'b1;
            else if (hit_2)
                dir_x_next = 1'b0;

            // Wall bounces
            if (state_q.ball_y == 10'd0)
                dir_y_next = 1'b1;
            else if (state_q.ball_y + BALL_SIZE == FIELD_BOTTOM)
                dir_y_next = 1'b0;

            if (miss_1 || miss_2)
            begin
                // Serve from center towards whoever missed
                state_next.ball_x = BALL_START_X;
                state_next.ball_y = BALL_START_Y;
                dir_x_next        = miss_2;
                if (miss_1)
                    state_next.score_2 = state_q.score_2 + 8'd1;
                else
                    state_next.score_1 = state_q.score_1 + 8'd1;
            end
            else
            begin
                // One pixel per axis in the new directions
                state_next.ball_x = dir_x_next ? state_q.ball_x + 10'd1 : state_q.ball_x - 10'd1;
                state_next.ball_y = dir_y_next ? state_q.ball_y + 10'd1 : state_q.ball_y - 10'd1;
            end

            state_next.paddle_1_y = move_paddle(state_q.paddle_1_y, in_cmd.paddle_1);
            state_next.paddle_2_y = move_paddle(state_q.paddle_2_y, in_cmd.paddle_2);
        end
    end

    // State only advances when a command is taken, and that only happens
    // when the previous result is gone, so state doubles as the output
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;
    assign out_step = state_q;

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            state_q   <= START_FRAME;
            dir_x_q   <= 1'b1;
            dir_y_q   <= 1'b1;
            out_valid <= 1'b0;
        end
        else if (take)
        begin
            state_q   <= state_next;
            dir_x_q   <= dir_x_next;
            dir_y_q   <= dir_y_next;
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

endmodule

/* src/frame_result_buffer.sv */
`timescale 1ns/1ps

module frame_result_buffer import pong_frame_pkg::*;
(
    input  logic          clock,
    input  logic          resetn,

    // Step side from physics
    input  logic          in_valid,
    output logic          in_ready,
    input  frame_result_t in_step,

    // Result side to the consumer
    output logic          out_valid,
    input  logic          out_ready,
    output frame_result_t out_res
);

    logic take;     // Step transfer this cycle

    // Takes a new step when empty or when the held result leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clock)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
        end
        else if (take)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;  // Taken by the consumer
        end
    end

    // Holds while the consumer stalls
    always_ff @(posedge clock)
    begin
        if (take)
        begin
            out_res <= in_step;
        end
    end

endmodule

/* src/pong_step_engine.sv */
`timescale 1ns/1ps

module pong_step_engine import pong_frame_pkg::*;
(
    input  logic          clock,
    input  logic          resetn,

    // Frame requests
    input  logic          req_valid,
    output logic          req_ready,
    input  frame_req_t    req,

    // Frame results
    output logic          res_valid,
    input  logic          res_ready,
    output frame_result_t res
);

    // Decode to execute
    logic          cmd_valid;
    logic          cmd_ready;
    frame_cmd_t    cmd;

    // Execute to result buffer
    logic          step_valid;
    logic          step_ready;
    frame_result_t step;

    paddle_target_decode i_paddle_target_decode (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready),
        .out_cmd   (cmd)
    );

    pong_physics_execute i_pong_physics_execute (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_cmd    (cmd),
        .out_valid (step_valid),
        .out_ready (step_ready),
        .out_step  (step)
    );

    frame_result_buffer i_frame_result_buffer (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (step_valid),
        .in_ready  (step_ready),
        .in_step   (step),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_res   (res)
    );

endmodule

/* verif/pong_step_engine_asserts.sv */
`timescale 1ns/1ps

module pong_step_engine_asserts import pong_geometry_pkg::*, pong_frame_pkg::*;
(
    input logic          clock,
    input logic          resetn,
    input logic          req_valid,
    input logic          req_ready,
    input frame_req_t    req,
    input logic          res_valid,
    input logic          res_ready,
    input frame_result_t res
);

    // Request side holds until taken
    req_hold: assert property (@(posedge clock) disable iff (!resetn)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("Request dropped or changed while stalled");

    // Result side holds while the consumer stalls
    res_hold: assert property (@(posedge clock) disable iff (!resetn)
        (res_valid && !res_ready) |=> (res_valid && $stable(res)))
        else $error("Result dropped or changed while stalled");

    paddle_range: assert property (@(posedge clock) disable iff (!resetn)
        res_valid |-> (res.paddle_1_y <= PADDLE_MAX_Y && res.paddle_2_y <= PADDLE_MAX_Y))
        else $error("Paddle below the bottom of the field");

    // Nothing leaves the engine straight after reset
    reset_idle: assert property (@(posedge clock) !resetn |=> !res_valid)
        else $error("res_valid high after reset");

endmodule

bind pong_step_engine pong_step_engine_asserts i_pong_step_engine_asserts (.*);

/* verif/pong_step_engine_tb.sv */
`timescale 1ns/1ps

module pong_step_engine_tb import pong_geometry_pkg::*, pong_frame_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic          clock = 1'b0;
    logic          resetn;
    logic          req_valid;
    logic          req_ready;
    frame_req_t    req;
    logic          res_valid;
    logic          res_ready;
    frame_result_t res;

    logic [15:0]   lfsr_state;
    logic          stall_on;        // Random lows on res_ready
    string         current_test;
    int            cycle_count;
    int            sent_count;
    int            checked_count;
    frame_req_t    req_q[$];        // Accepted requests, oldest first
    string         name_q[$];
    int            accept_q[$];     // Cycle of acceptance
    frame_result_t ref_state;       // Reference game state
    logic          ref_dir_x;       // 1 moves right
    logic          ref_dir_y;       // 1 moves down

    pong_step_engine i_pong_step_engine (.*);

    always #20 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int unsigned expected,
                               input int unsigned actual);
        if (expected != actual)
            abort_run($sformatf("Error %s expected %0d actual %0d", name, expected, actual));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // Mostly in window, sometimes blind spot or out of range
    function automatic sensor_t random_sensor();
        int unsigned kind;
        kind = take_bits(4);
        if (kind < 12)
            return sensor_t'(SENSOR_MIN + take_bits(5) % (SENSOR_LIMIT - SENSOR_MIN));
        else if (kind < 14)
            return sensor_t'(take_bits(1));
        return sensor_t'(SENSOR_LIMIT + take_bits(8));
    endfunction

    function automatic frame_req_t make_req(input logic restart, input sensor_t s1,
                                            input sensor_t s2);
        frame_req_t r;
        r.restart  = restart;
        r.sensor_1 = s1;
        r.sensor_2 = s2;
        return r;
    endfunction

    function automatic int paddle_after(input int pos, input sensor_t reading);
        int target;
        int gap;
        int step;
        if (reading < SENSOR_MIN || reading >= SENSOR_LIMIT)
            return pos;                                 // Not tracking, holds
        target = (int'(reading) - int'(SENSOR_MIN)) * int'(SENSOR_SCALE);
        gap    = (target > pos) ? target - pos : pos - target;
        step   = (gap > 80) ? 40 : (gap > 50) ? 20 : (gap > 20) ? 4 : 1;
        if (step > gap)
            step = gap;                                 // Never overshoot
        pos = (target > pos) ? pos + step : pos - step;
        return (pos > int'(PADDLE_MAX_Y)) ? int'(PADDLE_MAX_Y) : pos;
    endfunction

    function automatic logic overlap(input int ball_y, input int paddle_y);
        return (ball_y + 2 >= paddle_y) && (ball_y <= paddle_y + 15);
    endfunction

    // Advances the reference state by one frame
    function automatic frame_result_t predict_frame(input frame_req_t r);
        int   bx;
        int   by;
        logic dx;
        logic dy;
        bx = ref_state.ball_x;
        by = ref_state.ball_y;
        dx = ref_dir_x;
        dy = ref_dir_y;
        if (r.restart)
        begin
            ref_state = '{BALL_START_X, BALL_START_Y, 10'd0, 10'd0, 8'd0, 8'd0};
            ref_dir_x = 1'b1;
            ref_dir_y = 1'b1;
            return ref_state;
        end
        if (!dx && bx == P1_X + 1 && overlap(by, ref_state.paddle_1_y))
            dx = 1'b1;
        else if (dx && bx + 2 == P2_X && overlap(by, ref_state.paddle_2_y))
            dx = 1'b0;
        if (by == 0)
            dy = 1'b1;
        else if (by + 2 == 118)
            dy = 1'b0;                                  // Bottom wall
        if (bx == P1_X - 1 || bx + 2 == P2_X + 1)
        begin
            if (bx == P1_X - 1)
                ref_state.score_2 = ref_state.score_2 + 8'd1;
            else
                ref_state.score_1 = ref_state.score_1 + 8'd1;
            dx = (bx != P1_X - 1);                      // Serve towards the loser
            bx = BALL_START_X;
            by = BALL_START_Y;
        end
        else
        begin
            bx = dx ? bx + 1 : bx - 1;
            by = dy ? by + 1 : by - 1;
        end
        ref_state.paddle_1_y = coord_t'(paddle_after(ref_state.paddle_1_y, r.sensor_1));
        ref_state.paddle_2_y = coord_t'(paddle_after(ref_state.paddle_2_y, r.sensor_2));
        ref_state.ball_x     = coord_t'(bx);
        ref_state.ball_y     = coord_t'(by);
        ref_dir_x            = dx;
        ref_dir_y            = dy;
        return ref_state;
    endfunction

    task automatic update_ready();
        res_ready = stall_on ? (take_bits(2) != 0) : 1'b1;
    endtask

    task automatic send_frame(input frame_req_t r, input logic gaps);
        int waited;
        waited = 0;
        while (gaps && take_bits(2) == 0)
        begin
            @(negedge clock);
            req_valid = 1'b0;                           // Idle cycle
            update_ready();
        end
        @(negedge clock);
        req_valid = 1'b1;
        req       = r;
        update_ready();
        @(posedge clock);
        while (!req_ready)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                abort_run("Timeout waiting for req_ready");
            @(negedge clock);
            update_ready();
            @(posedge clock);
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        @(negedge clock);
        req_valid = 1'b0;
        update_ready();
        while (req_q.size() != 0)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                abort_run("Timeout waiting for outstanding results");
            @(negedge clock);
            update_ready();
        end
    endtask

    // Records accepted requests and checks every result transfer
    always @(posedge clock)
    begin : compare_results
        frame_req_t    r;
        frame_result_t exp;
        string         name;
        int            accepted_at;
        if (resetn)
        begin
            cycle_count++;
            if (req_valid && req_ready)
            begin
                req_q.push_back(req);
                name_q.push_back(current_test);
                accept_q.push_back(cycle_count);
                sent_count++;
            end
            if (res_valid && res_ready)
            begin
                if (req_q.size() == 0)
                    abort_run("Result arrived with no request outstanding");
                else
                begin
                    r           = req_q.pop_front();
                    name        = name_q.pop_front();
                    accepted_at = accept_q.pop_front();
                    exp         = predict_frame(r);
                    check_value({name, " ball_x"}, exp.ball_x, res.ball_x);
                    check_value({name, " ball_y"}, exp.ball_y, res.ball_y);
                    check_value({name, " paddle_1_y"}, exp.paddle_1_y, res.paddle_1_y);
                    check_value({name, " paddle_2_y"}, exp.paddle_2_y, res.paddle_2_y);
                    check_value({name, " score_1"}, exp.score_1, res.score_1);
                    check_value({name, " score_2"}, exp.score_2, res.score_2);
                    if (name == "back_to_back")
                        check_value({name, " latency"}, 3, cycle_count - accepted_at);
                    checked_count++;
                end
            end
        end
    end

    initial
    begin : stimulus
        sensor_t s1;
        sensor_t s2;
        logic    restart;
        lfsr_state    = 16'd58806;
        resetn        = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        res_ready     = 1'b0;
        stall_on      = 1'b0;
        cycle_count   = 0;
        sent_count    = 0;
        checked_count = 0;
        ref_state     = '{BALL_START_X, BALL_START_Y, 10'd0, 10'd0, 8'd0, 8'd0};
        ref_dir_x     = 1'b1;
        ref_dir_y     = 1'b1;
        current_test  = "restart";
        repeat (4) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;

        send_frame(make_req(1'b1, 10'd7, 10'd7), 1'b0);
        drain_results();

        // Paddle 1 runs into the clamp, paddle 2 settles mid field
        current_test = "paddle_track";
        for (int i = 0; i < 24; i++)
            send_frame(make_req(1'b0, 10'd19, 10'd9), 1'b1);
        for (int i = 0; i < 24; i++)
            send_frame(make_req(1'b0, 10'd2, 10'd15), 1'b1);
        drain_results();

        current_test = "sensor_window";
        for (int i = 0; i < 16; i++)
            send_frame(make_req(1'b0, sensor_t'(i % 2), sensor_t'(20 + 37 * i)), 1'b1);
        drain_results();

        current_test = "random_play";
        stall_on     = 1'b1;
        for (int i = 0; i < 1500; i++)
        begin
            restart = (take_bits(8) == 0);
            s1      = random_sensor();
            s2      = random_sensor();
            send_frame(make_req(restart, s1, s2), 1'b1);
        end
        drain_results();
        stall_on = 1'b0;

        current_test = "back_to_back";
        for (int i = 0; i < 40; i++)
        begin
            s1 = random_sensor();
            s2 = random_sensor();
            send_frame(make_req(1'b0, s1, s2), 1'b0);
        end
        drain_results();

        if (checked_count == sent_count && checked_count > 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            abort_run("Number of results does not match accepted requests");
    end

endmodule

/* verilog.f */
src/pong_geometry_pkg.sv
src/pong_frame_pkg.sv
src/paddle_target_decode.sv
src/pong_physics_execute.sv
src/frame_result_buffer.sv
src/pong_step_engine.sv
verif/pong_step_engine_asserts.sv
verif/pong_step_engine_tb.sv
